/* verilog/lsb_cfg_pkg.sv */
// load/store buffer sizing
// widths, depth and tag types

package lsb_cfg_pkg;

    localparam int DATA_W    = 32;  // data and address
    localparam int ROB_W     = 4;
    localparam int LSB_DEPTH = 16;
    localparam int PTR_W     = 4;   // wraps at LSB_DEPTH

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ROB_W-1:0]  rob_tag_t;
    typedef logic [PTR_W-1:0]  lsb_ptr_t;

    // tag 0 is never a producer, operand already holds its value
    localparam rob_tag_t NO_DEP = '0;

endpackage

/* verilog/lsb_isa_pkg.sv */
// memory opcode encodings and helpers

package lsb_isa_pkg;

    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LH  = 4'd1,
        OP_LW  = 4'd2,
        OP_LBU = 4'd3,
        OP_LHU = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_t;

    typedef enum logic [1:0] {
        RW_BYTE = 2'd0,
        RW_HALF = 2'd1,
        RW_WORD = 2'd2
    } rw_style_t;

    function automatic logic is_load(input mem_op_t op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // access width seen by the memory dispatcher
    function automatic rw_style_t op_style(input mem_op_t op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return RW_BYTE;
            OP_LH, OP_LHU, OP_SH: return RW_HALF;
            default:              return RW_WORD;
        endcase
    endfunction

endpackage

/* verilog/load_return.sv */
// outstanding load and cdb broadcast
`timescale 1ns/1ps

module load_return
    import lsb_cfg_pkg::*;
    import lsb_isa_pkg::*;
(
    input  logic     in_clk,
    input  logic     in_rst,
    input  logic     flush,
    input  logic     load_issue,
    input  mem_op_t  issue_op,
    input  rob_tag_t issue_dest,
    input  logic     load_data_en,
    input  data_t    load_data,
    output logic     load_busy,
    output logic     cdb_en,
    output rob_tag_t cdb_tag,
    output data_t    cdb_value
);

    mem_op_t  op_q;
    rob_tag_t dest_q;
    data_t    ext_data;

    always_comb begin
        case (op_q)
            OP_LB:   ext_data = {{(DATA_W-8){load_data[7]}}, load_data[7:0]};
            OP_LH:   ext_data = {{(DATA_W-16){load_data[15]}}, load_data[15:0]};
            OP_LBU:  ext_data = {{(DATA_W-8){1'b0}}, load_data[7:0]};
            OP_LHU:  ext_data = {{(DATA_W-16){1'b0}}, load_data[15:0]};
            default: ext_data = load_data;  // lw
        endcase
    end

    // flush drops the pending load, its data is ignored
    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            load_busy <= 1'b0;
            cdb_en    <= 1'b0;
        end else begin
            cdb_en <= load_data_en && load_busy;
            if (load_data_en && load_busy)
                load_busy <= 1'b0;
            else if (load_issue)
                load_busy <= 1'b1;
        end
    end

    always_ff @(posedge in_clk) begin
        if (load_issue) begin
            op_q   <= issue_op;
            dest_q <= issue_dest;
        end
        if (load_data_en) begin
            cdb_tag   <= dest_q;
            cdb_value <= ext_data;
        end
    end

endmodule

/* verilog/lsb_entry_file.sv */
// load/store buffer entries with tag wakeup
`timescale 1ns/1ps

module lsb_entry_file
    import lsb_cfg_pkg::*;
    import lsb_isa_pkg::*;
(
    input  logic     in_clk,
    input  logic     in_rst,
    input  logic     flush,
    input  logic     wr_en,
    input  lsb_ptr_t wr_ptr,
    input  lsb_ptr_t rd_ptr,
    input  logic     pop,
    input  mem_op_t  op,
    input  data_t    imm,
    input  rob_tag_t qj,
    input  rob_tag_t qk,
    input  data_t    vj,
    input  data_t    vk,
    input  rob_tag_t dest,
    input  logic     bc0_en,
    input  rob_tag_t bc0_tag,
    input  data_t    bc0_value,
    input  logic     bc1_en,
    input  rob_tag_t bc1_tag,
    input  data_t    bc1_value,
    output mem_op_t  head_op,
    output rob_tag_t head_qj,
    output rob_tag_t head_qk,
    output data_t    head_addr,
    output data_t    head_vk,
    output rob_tag_t head_dest
);

    mem_op_t  op_mem   [LSB_DEPTH];
    data_t    imm_mem  [LSB_DEPTH];
    rob_tag_t qj_mem   [LSB_DEPTH];
    rob_tag_t qk_mem   [LSB_DEPTH];
    data_t    vj_mem   [LSB_DEPTH];
    data_t    vk_mem   [LSB_DEPTH];
    rob_tag_t dest_mem [LSB_DEPTH];
    logic [LSB_DEPTH-1:0] busy;

    rob_tag_t wr_qj, wr_qk;
    data_t    wr_vj, wr_vk;

    function automatic logic hit(input logic en, input rob_tag_t q, input rob_tag_t tag);
        return en && q != NO_DEP && q == tag;
    endfunction

    // bypass a broadcast landing in the assign cycle
    always_comb begin
        wr_qj = qj;
        wr_vj = vj;
        wr_qk = qk;
        wr_vk = vk;
        if (hit(bc0_en, qj, bc0_tag)) begin
            wr_qj = NO_DEP;
            wr_vj = bc0_value;
        end
        if (hit(bc1_en, qj, bc1_tag)) begin
            wr_qj = NO_DEP;
            wr_vj = bc1_value;
        end
        if (hit(bc0_en, qk, bc0_tag)) begin
            wr_qk = NO_DEP;
            wr_vk = bc0_value;
        end
        if (hit(bc1_en, qk, bc1_tag)) begin
            wr_qk = NO_DEP;
            wr_vk = bc1_value;
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            busy <= '0;
        end else begin
            if (pop)
                busy[rd_ptr] <= 1'b0;
            if (wr_en)
                busy[wr_ptr] <= 1'b1;
        end
    end

    always_ff @(posedge in_clk) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (wr_en && wr_ptr == lsb_ptr_t'(i)) begin
                op_mem[i]   <= op;
                imm_mem[i]  <= imm;
                dest_mem[i] <= dest;
                qj_mem[i]   <= wr_qj;
                vj_mem[i]   <= wr_vj;
                qk_mem[i]   <= wr_qk;
                vk_mem[i]   <= wr_vk;
            end else if (busy[i]) begin
                if (hit(bc0_en, qj_mem[i], bc0_tag)) begin
                    qj_mem[i] <= NO_DEP;
                    vj_mem[i] <= bc0_value;
                end
                if (hit(bc1_en, qj_mem[i], bc1_tag)) begin
                    qj_mem[i] <= NO_DEP;
                    vj_mem[i] <= bc1_value;
                end
                if (hit(bc0_en, qk_mem[i], bc0_tag)) begin
                    qk_mem[i] <= NO_DEP;
                    vk_mem[i] <= bc0_value;
                end
                if (hit(bc1_en, qk_mem[i], bc1_tag)) begin
                    qk_mem[i] <= NO_DEP;
                    vk_mem[i] <= bc1_value;
                end
            end
        end
    end

    assign head_op   = op_mem[rd_ptr];
    assign head_qj   = qj_mem[rd_ptr];
    assign head_qk   = qk_mem[rd_ptr];
    assign head_vk   = vk_mem[rd_ptr];
    assign head_dest = dest_mem[rd_ptr];
    assign head_addr = vj_mem[rd_ptr] + imm_mem[rd_ptr];  // effective address

endmodule

/* verilog/lsb_ctrl.sv */
// load/store buffer control
// queue pointers, head issue and store commit
`timescale 1ns/1ps

module lsb_ctrl
    import lsb_cfg_pkg::*;
    import lsb_isa_pkg::*;
(
    input  logic      in_clk,
    input  logic      in_rst,
    input  logic      flush,
    input  logic      assign_en,
    output logic      full,
    output lsb_ptr_t  head_ptr,
    output lsb_ptr_t  tail_ptr,
    output logic      pop,
    input  mem_op_t   head_op,
    input  rob_tag_t  head_qj,
    input  rob_tag_t  head_qk,
    input  data_t     head_addr,
    input  data_t     head_vk,
    input  rob_tag_t  head_dest,
    input  logic      load_busy,
    output logic      load_issue,
    input  logic      rob_store_en,
    input  logic      load_req_en,
    input  logic      store_req_en,
    output logic      load_req,
    output data_t     load_addr,
    output rw_style_t load_style,
    output logic      store_req,
    output data_t     store_addr,
    output data_t     store_value,
    output rw_style_t store_style,
    output logic      rob_store_over,
    output rob_tag_t  rob_store_tag
);

    logic empty;
    logic store_wait;   // request sent, waiting for second pass
    logic store_stall;  // rob head not yet updated after store over
    logic store_ready;
    logic store_issue;
    logic store_done;

    assign full = (head_ptr == tail_ptr) && !empty;

    assign load_issue = !empty && is_load(head_op) && head_qj == NO_DEP
                        && load_req_en && !load_busy;

    always_comb begin
        store_ready = !empty && is_store(head_op)
                      && head_qj == NO_DEP && head_qk == NO_DEP
                      && rob_store_en && !store_stall && store_req_en;
    end

    assign store_issue = store_ready && !store_wait;
    assign store_done  = store_ready && store_wait;
    assign pop         = load_issue || store_done;

    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            head_ptr    <= '0;
            tail_ptr    <= '0;
            empty       <= 1'b1;
            store_wait  <= 1'b0;
            store_stall <= 1'b0;
        end else begin
            if (assign_en)
                tail_ptr <= tail_ptr + 1'b1;
            if (pop)
                head_ptr <= head_ptr + 1'b1;
            if (assign_en && !pop)
                empty <= 1'b0;
            else if (pop && !assign_en)
                empty <= lsb_ptr_t'(head_ptr + 1'b1) == tail_ptr;  // last entry leaving
            if (store_ready)
                store_wait <= !store_wait;
            store_stall <= store_done;
        end
    end

    // one-cycle strobes
    always_ff @(posedge in_clk) begin
        if (in_rst || flush) begin
            load_req       <= 1'b0;
            store_req      <= 1'b0;
            rob_store_over <= 1'b0;
        end else begin
            load_req       <= load_issue;
            store_req      <= store_issue;
            rob_store_over <= store_done;
        end
    end

    always_ff @(posedge in_clk) begin
        if (load_issue) begin
            load_addr  <= head_addr;
            load_style <= op_style(head_op);
        end
        if (store_issue) begin
            store_addr  <= head_addr;
            store_value <= head_vk;
            store_style <= op_style(head_op);
        end
        if (store_done)
            rob_store_tag <= head_dest;
    end

endmodule

/* verilog/lsb_top.sv */
// load/store buffer top level
`timescale 1ns/1ps

module lsb_top
    import lsb_cfg_pkg::*;
    import lsb_isa_pkg::*;
(
    input  logic      in_clk,
    input  logic      in_rst,
    input  logic      flush,
    output logic      full,
    // decoder
    input  logic      assign_en,
    input  mem_op_t   op,
    input  data_t     imm,
    input  data_t     vj,
    input  data_t     vk,
    input  rob_tag_t  qj,
    input  rob_tag_t  qk,
    input  rob_tag_t  dest,
    // alu result bus
    input  logic      alu_bc_en,
    input  rob_tag_t  alu_bc_tag,
    input  data_t     alu_bc_value,
    // rob
    input  logic      rob_store_en,
    output logic      rob_store_over,
    output rob_tag_t  rob_store_tag,
    // memory dispatcher
    output logic      load_req,
    output data_t     load_addr,
    output rw_style_t load_style,
    input  logic      load_req_en,
    input  logic      load_data_en,
    input  data_t     load_data,
    output logic      store_req,
    output data_t     store_addr,
    output data_t     store_value,
    output rw_style_t store_style,
    input  logic      store_req_en,
    // common data bus
    output logic      cdb_en,
    output rob_tag_t  cdb_tag,
    output data_t     cdb_value
);

    lsb_ptr_t head_ptr;
    lsb_ptr_t tail_ptr;
    logic     pop;
    mem_op_t  head_op;
    rob_tag_t head_qj;
    rob_tag_t head_qk;
    data_t    head_addr;
    data_t    head_vk;
    rob_tag_t head_dest;
    logic     load_busy;
    logic     load_issue;

    lsb_ctrl lsb_ctrl_inst (
        .in_clk         (in_clk),
        .in_rst         (in_rst),
        .flush          (flush),
        .assign_en      (assign_en),
        .full           (full),
        .head_ptr       (head_ptr),
        .tail_ptr       (tail_ptr),
        .pop            (pop),
        .head_op        (head_op),
        .head_qj        (head_qj),
        .head_qk        (head_qk),
        .head_addr      (head_addr),
        .head_vk        (head_vk),
        .head_dest      (head_dest),
        .load_busy      (load_busy),
        .load_issue     (load_issue),
        .rob_store_en   (rob_store_en),
        .load_req_en    (load_req_en),
        .store_req_en   (store_req_en),
        .load_req       (load_req),
        .load_addr      (load_addr),
        .load_style     (load_style),
        .store_req      (store_req),
        .store_addr     (store_addr),
        .store_value    (store_value),
        .store_style    (store_style),
        .rob_store_over (rob_store_over),
        .rob_store_tag  (rob_store_tag)
    );

    // bc1 is our own cdb, looped back for wakeup
    lsb_entry_file lsb_entry_file_inst (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .flush     (flush),
        .wr_en     (assign_en),
        .wr_ptr    (tail_ptr),
        .rd_ptr    (head_ptr),
        .pop       (pop),
        .op        (op),
        .imm       (imm),
        .qj        (qj),
        .qk        (qk),
        .vj        (vj),
        .vk        (vk),
        .dest      (dest),
        .bc0_en    (alu_bc_en),
        .bc0_tag   (alu_bc_tag),
        .bc0_value (alu_bc_value),
        .bc1_en    (cdb_en),
        .bc1_tag   (cdb_tag),
        .bc1_value (cdb_value),
        .head_op   (head_op),
        .head_qj   (head_qj),
        .head_qk   (head_qk),
        .head_addr (head_addr),
        .head_vk   (head_vk),
        .head_dest (head_dest)
    );

    load_return load_return_inst (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .flush        (flush),
        .load_issue   (load_issue),
        .issue_op     (head_op),
        .issue_dest   (head_dest),
        .load_data_en (load_data_en),
        .load_data    (load_data),
        .load_busy    (load_busy),
        .cdb_en       (cdb_en),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value)
    );

endmodule

/* include/lsb_tb_tasks.svh */
// directed tests for the load/store buffer
`ifndef LSB_TB_TASKS_SVH
`define LSB_TB_TASKS_SVH

localparam int SIG_LOAD_REQ   = 0;
localparam int SIG_STORE_REQ  = 1;
localparam int SIG_STORE_OVER = 2;
localparam int SIG_CDB        = 3;
localparam int WAIT_LIMIT     = 50;

// inputs change 2 ns after the edge, outputs are settled by then
task automatic tick();
    @(posedge in_clk);
    #2;
endtask

task automatic check(input logic ok, input string msg);
    check_count++;
    assert (ok) else begin
        $display("** Error at %0t: %s", $time, msg);
        error_count++;
    end
endtask

function automatic logic strobe_level(input int sel);
    case (sel)
        SIG_LOAD_REQ:   return load_req;
        SIG_STORE_REQ:  return store_req;
        SIG_STORE_OVER: return rob_store_over;
        default:        return cdb_en;
    endcase
endfunction

// current cycle counts too, a pulse may already be up
task automatic wait_high(input int sel, input string what, output logic seen);
    int n;
    n    = 0;
    seen = strobe_level(sel);
    while (!seen && n < WAIT_LIMIT) begin
        tick();
        n++;
        seen = strobe_level(sel);
    end
    if (!seen) begin
        $display("timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        error_count++;
    end
endtask

task automatic expect_quiet(input int cycles, input string what);
    for (int n = 0; n < cycles; n++) begin
        tick();
        check(!load_req && !store_req && !rob_store_over && !cdb_en,
              $sformatf("unexpected strobe, %s", what));
    end
endtask

function automatic data_t expected_ext(input mem_op_t ld_op, input data_t raw);
    data_t b;
    data_t h;
    b = {24'd0, raw[7:0]};
    h = {16'd0, raw[15:0]};
    case (ld_op)
        OP_LB:   return raw[7] ? (b | 32'hffff_ff00) : b;
        OP_LH:   return raw[15] ? (h | 32'hffff_0000) : h;
        OP_LBU:  return b;
        OP_LHU:  return h;
        default: return raw;
    endcase
endfunction

function automatic rw_style_t expected_style(input mem_op_t mop);
    if (mop == OP_LB || mop == OP_LBU || mop == OP_SB)
        return RW_BYTE;
    if (mop == OP_LH || mop == OP_LHU || mop == OP_SH)
        return RW_HALF;
    return RW_WORD;
endfunction

task automatic assign_entry(input mem_op_t new_op, input data_t new_imm,
                            input rob_tag_t new_qj, input data_t new_vj,
                            input rob_tag_t new_qk, input data_t new_vk,
                            input rob_tag_t new_dest);
    assign_en = 1'b1;
    op        = new_op;
    imm       = new_imm;
    qj        = new_qj;
    vj        = new_vj;
    qk        = new_qk;
    vk        = new_vk;
    dest      = new_dest;
    tick();
    assign_en = 1'b0;
endtask

// one-cycle data return, then wait for the broadcast
task automatic return_load(input data_t raw, output logic seen);
    load_data_en = 1'b1;
    load_data    = raw;
    tick();
    load_data_en = 1'b0;
    check(!load_req, "load_req held longer than one cycle");
    wait_high(SIG_CDB, "cdb_en", seen);
endtask

task automatic report_test(input string name, input int errs_before);
    test_count++;
    $display("%-16s %s (%0d errors)", name,
             (error_count == errs_before) ? "ok" : "failed", error_count - errs_before);
endtask

task automatic test_load_format();
    mem_op_t  ops [5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    int       errs_before;
    data_t    base;
    data_t    offs;
    data_t    raw;
    rob_tag_t tag;
    logic     seen;
    errs_before = error_count;
    for (int n = 0; n < 5; n++) begin
        base = $urandom();
        offs = $urandom();
        raw  = $urandom();
        tag  = rob_tag_t'(n + 1);
        assign_entry(ops[n], offs, NO_DEP, base, NO_DEP, '0, tag);
        wait_high(SIG_LOAD_REQ, "load_req", seen);
        if (seen) begin
            check(load_addr == base + offs,
                  $sformatf("op %0d load_addr %h, expected %h", ops[n], load_addr, base + offs));
            check(load_style == expected_style(ops[n]),
                  $sformatf("op %0d load_style %0d", ops[n], load_style));
        end
        return_load(raw, seen);
        if (seen) begin
            check(cdb_tag == tag, $sformatf("cdb_tag %0d, expected %0d", cdb_tag, tag));
            check(cdb_value == expected_ext(ops[n], raw),
                  $sformatf("op %0d cdb_value %h, expected %h", ops[n], cdb_value,
                            expected_ext(ops[n], raw)));
        end
    end
    report_test("load format", errs_before);
endtask

task automatic test_store_commit();
    int    errs_before;
    data_t base;
    data_t offs;
    data_t val;
    logic  seen;
    errs_before = error_count;
    base = $urandom();
    offs = $urandom();
    val  = $urandom();
    rob_store_en = 1'b0;
    assign_entry(OP_SH, offs, NO_DEP, base, NO_DEP, val, 4'd7);
    expect_quiet(5, "store before rob_store_en");
    rob_store_en = 1'b1;  // store reaches rob head
    wait_high(SIG_STORE_REQ, "store_req", seen);
    if (seen) begin
        check(store_addr == base + offs,
              $sformatf("store_addr %h, expected %h", store_addr, base + offs));
        check(store_value == val, $sformatf("store_value %h, expected %h", store_value, val));
        check(store_style == RW_HALF, $sformatf("store_style %0d", store_style));
    end
    wait_high(SIG_STORE_OVER, "rob_store_over", seen);
    if (seen)
        check(rob_store_tag == 4'd7, $sformatf("rob_store_tag %0d, expected 7", rob_store_tag));
    check(!full, "full high after store commit");
    expect_quiet(4, "after store commit");  // rob head still a store, a stale entry would fire
    rob_store_en = 1'b0;
    report_test("store commit", errs_before);
endtask

task automatic test_alu_wakeup();
    int    errs_before;
    data_t offs;
    data_t val;
    data_t raw;
    logic  seen;
    errs_before = error_count;
    offs = $urandom();
    val  = $urandom();
    raw  = $urandom();
    assign_entry(OP_LW, offs, 4'd5, $urandom(), NO_DEP, '0, 4'd8);  // vj stale until tag 5
    expect_quiet(5, "load with pending qj");
    alu_bc_en    = 1'b1;
    alu_bc_tag   = 4'd5;
    alu_bc_value = val;
    tick();
    alu_bc_en = 1'b0;
    wait_high(SIG_LOAD_REQ, "load_req after alu wakeup", seen);
    if (seen)
        check(load_addr == val + offs,
              $sformatf("load_addr %h, expected %h", load_addr, val + offs));
    return_load(raw, seen);
    if (seen)
        check(cdb_tag == 4'd8 && cdb_value == raw, "wrong broadcast after alu wakeup");
    report_test("alu wakeup", errs_before);
endtask

task automatic test_cdb_wakeup();
    int    errs_before;
    data_t base_a;
    data_t offs_a;
    data_t offs_b;
    data_t raw_a;
    logic  seen;
    errs_before = error_count;
    base_a = $urandom();
    offs_a = $urandom();
    offs_b = $urandom();
    raw_a  = $urandom();
    assign_entry(OP_LW, offs_a, NO_DEP, base_a, NO_DEP, '0, 4'd3);
    assign_entry(OP_LW, offs_b, 4'd3, $urandom(), NO_DEP, '0, 4'd4);  // waits on load a
    wait_high(SIG_LOAD_REQ, "load_req for load A", seen);
    if (seen)
        check(load_addr == base_a + offs_a, $sformatf("load A addr %h", load_addr));
    expect_quiet(4, "load A outstanding");
    return_load(raw_a, seen);
    if (seen)
        check(cdb_tag == 4'd3 && cdb_value == raw_a, "wrong broadcast for load A");
    check(!load_req, "load B requested together with broadcast of A");
    wait_high(SIG_LOAD_REQ, "load_req for load B", seen);
    if (seen)
        check(load_addr == raw_a + offs_b,
              $sformatf("load B addr %h, expected %h", load_addr, raw_a + offs_b));
    return_load($urandom(), seen);
    if (seen)
        check(cdb_tag == 4'd4, $sformatf("load B cdb_tag %0d, expected 4", cdb_tag));
    report_test("cdb wakeup", errs_before);
endtask

task automatic test_full_flush();
    int   errs_before;
    logic seen;
    errs_before = error_count;
    assign_entry(OP_LBU, $urandom(), NO_DEP, $urandom(), NO_DEP, '0, 4'd2);
    wait_high(SIG_LOAD_REQ, "load_req before flush", seen);
    // fill every slot with loads stuck on tag 9
    for (int n = 0; n < LSB_DEPTH; n++)
        assign_entry(OP_LW, $urandom(), 4'd9, $urandom(), NO_DEP, '0, rob_tag_t'(n % 15 + 1));
    check(full, "full low with every entry in use");
    flush = 1'b1;
    tick();
    flush = 1'b0;
    check(!full, "full high after flush");
    load_data_en = 1'b1;  // data for the discarded load
    load_data    = $urandom();
    tick();
    load_data_en = 1'b0;
    check(!cdb_en, "cdb_en raised for a flushed load");
    expect_quiet(6, "idle after flush");
    report_test("full and flush", errs_before);
endtask

`endif

/* tests/tb_lsb.sv */
// load/store buffer testbench
`timescale 1ns/1ps

module tb_lsb
    import lsb_cfg_pkg::*;
    import lsb_isa_pkg::*;
();

    logic      in_clk;
    logic      in_rst;
    logic      flush;
    logic      full;
    logic      assign_en;
    mem_op_t   op;
    data_t     imm;
    data_t     vj;
    data_t     vk;
    rob_tag_t  qj;
    rob_tag_t  qk;
    rob_tag_t  dest;
    logic      alu_bc_en;
    rob_tag_t  alu_bc_tag;
    data_t     alu_bc_value;
    logic      rob_store_en;
    logic      rob_store_over;
    rob_tag_t  rob_store_tag;
    logic      load_req;
    data_t     load_addr;
    rw_style_t load_style;
    logic      load_req_en;
    logic      load_data_en;
    data_t     load_data;
    logic      store_req;
    data_t     store_addr;
    data_t     store_value;
    rw_style_t store_style;
    logic      store_req_en;
    logic      cdb_en;
    rob_tag_t  cdb_tag;
    data_t     cdb_value;

    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;

    lsb_top lsb_top_inst (.*);

    always #10 in_clk = ~in_clk;  // 20 ns period

    `include "lsb_tb_tasks.svh"

    initial begin
        int seed_draw;
        seed_draw    = $urandom(8519);
        in_clk       = 1'b0;
        in_rst       = 1'b1;
        flush        = 1'b0;
        assign_en    = 1'b0;
        op           = OP_LW;
        imm          = '0;
        vj           = '0;
        vk           = '0;
        qj           = NO_DEP;
        qk           = NO_DEP;
        dest         = '0;
        alu_bc_en    = 1'b0;
        alu_bc_tag   = '0;
        alu_bc_value = '0;
        rob_store_en = 1'b0;
        load_req_en  = 1'b1;   // dispatcher always ready here
        store_req_en = 1'b1;
        load_data_en = 1'b0;
        load_data    = '0;

        repeat (3) @(posedge in_clk);
        #2;
        in_rst = 1'b0;

        test_load_format();
        test_store_commit();
        test_alu_wakeup();
        test_cdb_wakeup();
        test_full_flush();

        $display("tests: %0d  checks: %0d  errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
verilog/lsb_cfg_pkg.sv
verilog/lsb_isa_pkg.sv
verilog/load_return.sv
verilog/lsb_entry_file.sv
verilog/lsb_ctrl.sv
verilog/lsb_top.sv
tests/tb_lsb.sv
